//--- Makefile
# Verilator flow for the dino run core

VERILATOR ?= verilator
TOP       ?= dino_run_tb
RTL_TOP   ?= dino_run
FILELIST  ?= dino_run.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall

SOURCES   := $(shell grep -v '^+' $(FILELIST))
RTL_FILES ?= $(filter logic/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dino_run.f
logic/dino_run_pkg.sv
logic/raster_if.sv
logic/vga_timing.sv
logic/motion_clock.sv
logic/obstacle_lane.sv
logic/game_state.sv
logic/pixel_painter.sv
logic/dino_run.sv
sim/dino_run_checks.sv
sim/dino_run_tb.sv

//--- logic/dino_run.sv
// Dino runner game core
`timescale 1ns/1ps

module dino_run #(
    parameter int MOTION_TICKS = 2_000_000
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [7:0]                       controller_report,
    output logic [7:0]                       vga_r,
    output logic [7:0]                       vga_g,
    output logic [7:0]                       vga_b,
    output logic                             vga_clk,
    output logic                             vga_hs,
    output logic                             vga_vs,
    output logic                             vga_blank_n,
    output logic                             vga_sync_n,
    output logic [dino_run_pkg::SCORE_W-1:0] score
);
    import dino_run_pkg::*;

    raster_if raster ();

    logic                 step;
    logic                 restart;
    logic                 game_over;
    logic [NUM_LANES-1:0] hit;
    logic [NUM_LANES-1:0] covers;

    vga_timing u_timing (
        .clk    (clk),
        .reset  (reset),
        .raster (raster)
    );

    motion_clock #(
        .MOTION_TICKS (MOTION_TICKS)
    ) u_motion (
        .clk       (clk),
        .reset     (reset),
        .game_over (game_over),
        .step      (step)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        obstacle_lane #(
            .LANE (i)
        ) u_lane (
            .clk     (clk),
            .reset   (reset),
            .step    (step),
            .restart (restart),
            .raster  (raster),
            .hit     (hit[i]),
            .covers  (covers[i])
        );
    end

    game_state u_state (
        .clk       (clk),
        .reset     (reset),
        .step      (step),
        .hit       (hit),
        .replay    (controller_report[REPLAY_BIT]),
        .game_over (game_over),
        .restart   (restart),
        .score     (score)
    );

    pixel_painter u_painter (
        .clk       (clk),
        .reset     (reset),
        .game_over (game_over),
        .covers    (covers),
        .raster    (raster),
        .rgb_r     (vga_r),
        .rgb_g     (vga_g),
        .rgb_b     (vga_b)
    );

    // VGA pins
    assign vga_clk     = raster.pix_clk;
    assign vga_hs      = raster.hsync_n;
    assign vga_vs      = raster.vsync_n;
    assign vga_blank_n = raster.blank_n;
    assign vga_sync_n  = 1'b0;

endmodule

//--- logic/dino_run_pkg.sv
// Dino run shared constants
package dino_run_pkg;

    // Raster coordinate width
    localparam int COORD_W = 11;

    // Horizontal timing in clock cycles
    localparam logic [10:0] H_ACTIVE = 11'd1280;
    localparam logic [10:0] H_FRONT  = 11'd32;
    localparam logic [10:0] H_SYNC   = 11'd192;
    localparam logic [10:0] H_BACK   = 11'd96;
    localparam logic [10:0] H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // Vertical timing in lines
    localparam logic [9:0] V_ACTIVE = 10'd480;
    localparam logic [9:0] V_FRONT  = 10'd10;
    localparam logic [9:0] V_SYNC   = 10'd2;
    localparam logic [9:0] V_BACK   = 10'd33;
    localparam logic [9:0] V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Lanes: small cactus, cactus group, lava, pterodactyl
    localparam int NUM_LANES = 4;
    localparam logic [10:0] LANE_START_X [NUM_LANES] = '{11'd1200, 11'd1600, 11'd1800, 11'd1400};
    localparam logic [10:0] LANE_Y       [NUM_LANES] = '{11'd248, 11'd248, 11'd248, 11'd200};
    localparam logic [10:0] LANE_W       [NUM_LANES] = '{11'd32, 11'd64, 11'd32, 11'd32};

    // All boxes share one height
    localparam logic [10:0] OBJ_H = 11'd32;

    localparam logic [10:0] DINO_X = 11'd100;
    localparam logic [10:0] DINO_Y = 11'd248;
    localparam logic [10:0] DINO_W = 11'd32;

    localparam logic [10:0] BANNER_X = 11'd560;
    localparam logic [10:0] BANNER_Y = 11'd200;
    localparam logic [10:0] BANNER_W = 11'd160;

    localparam logic [23:0] SKY_RGB    = 24'h87CEEB;
    localparam logic [23:0] DINO_RGB   = 24'h535353;
    localparam logic [23:0] BANNER_RGB = 24'hFFD700;
    localparam logic [23:0] LANE_RGB [NUM_LANES] = '{24'h2E8B57, 24'h006400, 24'hFF4500, 24'h8B4513};

    localparam int          SCORE_W   = 17;
    localparam logic [16:0] SCORE_MAX = 17'd99999;

    // Controller report bit for replay
    localparam int REPLAY_BIT = 4;

endpackage

//--- logic/game_state.sv
// Run state, replay and score
`timescale 1ns/1ps

module game_state (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               step,
    input  logic [dino_run_pkg::NUM_LANES-1:0] hit,
    input  logic                               replay,
    output logic                               game_over,
    output logic                               restart,
    output logic [dino_run_pkg::SCORE_W-1:0]   score
);
    import dino_run_pkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            game_over <= 1'b0;
            restart   <= 1'b0;
        end else begin
            restart <= 1'b0;
            if (game_over) begin
                if (replay) begin
                    game_over <= 1'b0;
                    restart   <= 1'b1;
                end
            end else if (|hit && !restart) begin
                // Hit is stale until the lanes reload on restart
                game_over <= 1'b1;
            end
        end
    end

    // Kept across replay
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score <= '0;
        end else if (step) begin
            score <= (score == SCORE_MAX) ? '0 : score + 1'b1;
        end
    end

endmodule

//--- logic/motion_clock.sv
// Obstacle step divider
`timescale 1ns/1ps

module motion_clock #(
    parameter int MOTION_TICKS = 2_000_000
) (
    input  logic clk,
    input  logic reset,
    input  logic game_over,
    output logic step
);
    localparam int TICK_W = $clog2(MOTION_TICKS + 1);

    logic [TICK_W-1:0] ticks;
    logic              last_tick;

    assign last_tick = (ticks == TICK_W'(MOTION_TICKS - 1));

    // Holds its count while the game is over
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ticks <= '0;
        end else if (!game_over) begin
            if (last_tick) begin
                ticks <= '0;
            end else begin
                ticks <= ticks + 1'b1;
            end
        end
    end

    assign step = last_tick && !game_over;

endmodule

//--- logic/obstacle_lane.sv
// Obstacle lane position and box tests
`timescale 1ns/1ps

module obstacle_lane #(
    parameter int LANE = 0
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   step,
    input  logic   restart,
    raster_if.sink raster,
    output logic   hit,
    output logic   covers
);
    import dino_run_pkg::*;

    logic [COORD_W-1:0] x;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x <= LANE_START_X[LANE];
        end else if (restart) begin
            x <= LANE_START_X[LANE];
        end else if (step) begin
            x <= x - 1'b1;
        end
    end

    // Overlap with the dino box, strict on both axes
    assign hit = (x < DINO_X + DINO_W) &&
                 (x + LANE_W[LANE] > DINO_X) &&
                 (LANE_Y[LANE] < DINO_Y + OBJ_H) &&
                 (LANE_Y[LANE] + OBJ_H > DINO_Y);

    // Raster inside this obstacle
    assign covers = (raster.hcount >= x) &&
                    (raster.hcount < x + LANE_W[LANE]) &&
                    (raster.vcount >= LANE_Y[LANE]) &&
                    (raster.vcount < LANE_Y[LANE] + OBJ_H);

endmodule

//--- logic/pixel_painter.sv
// Flat colour painter
`timescale 1ns/1ps

module pixel_painter (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               game_over,
    input  logic [dino_run_pkg::NUM_LANES-1:0] covers,
    raster_if.sink                             raster,
    output logic [7:0]                         rgb_r,
    output logic [7:0]                         rgb_g,
    output logic [7:0]                         rgb_b
);
    import dino_run_pkg::*;

    logic        in_dino;
    logic        in_banner;
    logic [23:0] colour;
    logic [23:0] rgb_q;

    assign in_dino = (raster.hcount >= DINO_X) &&
                     (raster.hcount < DINO_X + DINO_W) &&
                     (raster.vcount >= DINO_Y) &&
                     (raster.vcount < DINO_Y + OBJ_H);

    assign in_banner = (raster.hcount >= BANNER_X) &&
                       (raster.hcount < BANNER_X + BANNER_W) &&
                       (raster.vcount >= BANNER_Y) &&
                       (raster.vcount < BANNER_Y + OBJ_H);

    // Later layers overwrite earlier ones
    always_comb begin
        colour = SKY_RGB;
        if (game_over) begin
            if (in_banner) begin
                colour = BANNER_RGB;
            end
        end else begin
            if (in_dino) begin
                colour = DINO_RGB;
            end
            // Higher lane index on top
            for (int i = 0; i < NUM_LANES; i++) begin
                if (covers[i]) begin
                    colour = LANE_RGB[i];
                end
            end
        end
    end

    // One cycle behind the raster counters
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rgb_q <= '0;
        end else begin
            rgb_q <= colour;
        end
    end

    assign rgb_r = rgb_q[23:16];
    assign rgb_g = rgb_q[15:8];
    assign rgb_b = rgb_q[7:0];

endmodule

//--- logic/raster_if.sv
// Raster position and sync
`timescale 1ns/1ps

interface raster_if;
    import dino_run_pkg::*;

    logic [COORD_W-1:0]        hcount;
    logic [$bits(V_TOTAL)-1:0] vcount;
    logic                      hsync_n;
    logic                      vsync_n;
    logic                      blank_n;
    logic                      pix_clk;

    modport source (output hcount, vcount, hsync_n, vsync_n, blank_n, pix_clk);
    modport sink   (input hcount, vcount);
    modport pins   (input hsync_n, vsync_n, blank_n, pix_clk);

endinterface

//--- logic/vga_timing.sv
// VGA raster timing generator
`timescale 1ns/1ps

module vga_timing (
    input  logic     clk,
    input  logic     reset,
    raster_if.source raster
);
    import dino_run_pkg::*;

    logic line_end;
    logic frame_end;

    assign line_end  = (raster.hcount == H_TOTAL - 1'b1);
    assign frame_end = (raster.vcount == V_TOTAL - 1'b1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raster.hcount <= '0;
        end else if (line_end) begin
            raster.hcount <= '0;
        end else begin
            raster.hcount <= raster.hcount + 1'b1;
        end
    end

    // Line counter steps once per line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raster.vcount <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                raster.vcount <= '0;
            end else begin
                raster.vcount <= raster.vcount + 1'b1;
            end
        end
    end

    assign raster.hsync_n = !((raster.hcount >= H_ACTIVE + H_FRONT) &&
                              (raster.hcount < H_ACTIVE + H_FRONT + H_SYNC));
    assign raster.vsync_n = !((raster.vcount >= V_ACTIVE + V_FRONT) &&
                              (raster.vcount < V_ACTIVE + V_FRONT + V_SYNC));
    assign raster.blank_n = (raster.hcount < H_ACTIVE) && (raster.vcount < V_ACTIVE);

    // Pixel clock at half the system clock
    assign raster.pix_clk = raster.hcount[0];

endmodule

//--- sim/dino_run_checks.sv
// Dino run reference model and checks
`timescale 1ns/1ps

module dino_run_checks #(
    parameter int MOTION_TICKS = 1024,
    parameter int RUN_CYCLES   = 4_200_000
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [7:0]                       controller_report,
    input  logic [7:0]                       vga_r,
    input  logic [7:0]                       vga_g,
    input  logic [7:0]                       vga_b,
    input  logic                             vga_clk,
    input  logic                             vga_hs,
    input  logic                             vga_vs,
    input  logic                             vga_blank_n,
    input  logic                             vga_sync_n,
    input  logic [dino_run_pkg::SCORE_W-1:0] score,
    output logic                             run_done,
    output logic                             check_error
);
    import dino_run_pkg::*;

    // Small cactus left edge drops below the dino's right edge here
    localparam int HIT_STEP = 1069;

    int          cyc;
    int          h_pos;
    int          v_pos;
    int          m_ticks;
    int          m_score;
    int          m_x [NUM_LANES];
    int          replays;
    logic        m_over;
    logic        m_restart;
    logic        m_step;
    logic        m_hit;
    logic        exp_hs;
    logic        exp_vs;
    logic        exp_blank;
    logic        exp_pix_clk;
    logic [23:0] rgb;
    logic [23:0] exp_rgb;
    logic        seen_banner;
    logic        seen_dino;
    logic        seen_cactus;

    function automatic logic in_box(input int h, input int v, input int bx, input int by,
                                    input int bw);
        return (h >= bx) && (h < bx + bw) && (v >= by) && (v < by + int'(OBJ_H));
    endfunction

    // Strict box overlap with the fixed dino
    function automatic logic lane_hits(input int x, input int lane);
        return (x < int'(DINO_X) + int'(DINO_W)) &&
               (x + int'(LANE_W[lane]) > int'(DINO_X)) &&
               (int'(LANE_Y[lane]) < int'(DINO_Y) + int'(OBJ_H)) &&
               (int'(LANE_Y[lane]) + int'(OBJ_H) > int'(DINO_Y));
    endfunction

    function automatic logic [23:0] expected_colour(input int h, input int v, input logic over);
        logic [23:0] c;
        c = SKY_RGB;
        if (over) begin
            if (in_box(h, v, int'(BANNER_X), int'(BANNER_Y), int'(BANNER_W))) begin
                c = BANNER_RGB;
            end
        end else begin
            if (in_box(h, v, int'(DINO_X), int'(DINO_Y), int'(DINO_W))) begin
                c = DINO_RGB;
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (in_box(h, v, m_x[i], int'(LANE_Y[i]), int'(LANE_W[i]))) begin
                    c = LANE_RGB[i];
                end
            end
        end
        return c;
    endfunction

    // Raster position follows from the cycle count alone
    assign h_pos       = cyc % int'(H_TOTAL);
    assign v_pos       = (cyc / int'(H_TOTAL)) % int'(V_TOTAL);
    assign exp_hs      = !((h_pos >= 1312) && (h_pos <= 1503));
    assign exp_vs      = !((v_pos >= 490) && (v_pos <= 491));
    assign exp_blank   = (h_pos < int'(H_ACTIVE)) && (v_pos < int'(V_ACTIVE));
    // Pixel clock is high on odd columns
    assign exp_pix_clk = (h_pos % 2) == 1;
    assign m_step      = (m_ticks == MOTION_TICKS - 1) && !m_over;
    assign rgb         = {vga_r, vga_g, vga_b};
    assign run_done    = (cyc >= RUN_CYCLES);

    always_comb begin
        m_hit = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_hits(m_x[i], i)) begin
                m_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cyc         <= 0;
            m_ticks     <= 0;
            m_score     <= 0;
            replays     <= 0;
            m_over      <= 1'b0;
            m_restart   <= 1'b0;
            exp_rgb     <= '0;
            seen_banner <= 1'b0;
            seen_dino   <= 1'b0;
            seen_cactus <= 1'b0;
            for (int i = 0; i < NUM_LANES; i++) begin
                m_x[i] <= int'(LANE_START_X[i]);
            end
        end else begin
            cyc       <= cyc + 1;
            exp_rgb   <= expected_colour(h_pos, v_pos, m_over);
            m_restart <= 1'b0;
            if (m_over) begin
                if (controller_report[REPLAY_BIT]) begin
                    m_over    <= 1'b0;
                    m_restart <= 1'b1;
                    replays   <= replays + 1;
                end
            end else if (m_hit && !m_restart) begin
                // Lanes reload one clock after restart so that cycle's hit is old
                m_over <= 1'b1;
            end
            if (!m_over) begin
                m_ticks <= (m_ticks == MOTION_TICKS - 1) ? 0 : m_ticks + 1;
            end
            if (m_step) begin
                m_score <= (m_score == int'(SCORE_MAX)) ? 0 : m_score + 1;
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (m_restart) begin
                    m_x[i] <= int'(LANE_START_X[i]);
                end else if (m_step) begin
                    m_x[i] <= m_x[i] - 1;
                end
            end
            if (m_over && in_box(h_pos, v_pos, int'(BANNER_X), int'(BANNER_Y),
                                 int'(BANNER_W))) begin
                seen_banner <= 1'b1;
            end
            if (replays > 0 && !m_over) begin
                if (in_box(h_pos, v_pos, int'(DINO_X), int'(DINO_Y), int'(DINO_W))) begin
                    seen_dino <= 1'b1;
                end
                if (in_box(h_pos, v_pos, m_x[0], int'(LANE_Y[0]), int'(LANE_W[0]))) begin
                    seen_cactus <= 1'b1;
                end
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        if (!check_error) begin
            $display("mismatch %s: got %h, expected %h", name, got, want);
            check_error = 1'b1;
        end
    endtask

    task automatic report_failure(input string what);
        if (!check_error) begin
            $display("%s", what);
            check_error = 1'b1;
        end
    endtask

    initial check_error = 1'b0;

    hsync_check: assert property (@(posedge clk) disable iff (reset) vga_hs == exp_hs)
        else report_mismatch("vga_hs", 32'($sampled(vga_hs)), 32'($sampled(exp_hs)));
    vsync_check: assert property (@(posedge clk) disable iff (reset) vga_vs == exp_vs)
        else report_mismatch("vga_vs", 32'($sampled(vga_vs)), 32'($sampled(exp_vs)));
    blank_check: assert property (@(posedge clk) disable iff (reset) vga_blank_n == exp_blank)
        else report_mismatch("vga_blank_n", 32'($sampled(vga_blank_n)),
                             32'($sampled(exp_blank)));
    pix_clk_check: assert property (@(posedge clk) disable iff (reset) vga_clk == exp_pix_clk)
        else report_mismatch("vga_clk", 32'($sampled(vga_clk)), 32'($sampled(exp_pix_clk)));
    sync_check: assert property (@(posedge clk) disable iff (reset) vga_sync_n == 1'b0)
        else report_mismatch("vga_sync_n", 32'($sampled(vga_sync_n)), 32'h0);
    score_check: assert property (@(posedge clk) disable iff (reset) int'(score) == m_score)
        else report_mismatch("score", 32'($sampled(score)), 32'($sampled(m_score)));
    hit_score_check: assert property (@(posedge clk) disable iff (reset)
        m_over |-> (int'(score) == HIT_STEP))
        else report_mismatch("score", 32'($sampled(score)), 32'(HIT_STEP));
    rgb_check: assert property (@(posedge clk) disable iff (reset) rgb == exp_rgb)
        else report_mismatch("rgb", 32'($sampled(rgb)), 32'($sampled(exp_rgb)));
    reach_check: assert property (@(posedge clk) disable iff (reset)
        run_done |-> (seen_banner && seen_dino && seen_cactus && replays == 1))
        else report_failure("run ended before collision, banner frame and replay were seen");

endmodule

//--- sim/dino_run_tb.sv
// Dino run testbench
`timescale 1ns/1ps

module dino_run_tb;
    import dino_run_pkg::*;

    localparam int MOTION_TICKS   = 1024;
    localparam int FRAME_CYCLES   = int'(H_TOTAL) * int'(V_TOTAL);
    // Frames: running, collision, banner, replay, running again
    localparam int RUN_CYCLES     = 5 * FRAME_CYCLES;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 200_000;
    // Late enough that the next hit falls after the last frame
    localparam int REPLAY_BASE    = 4 * FRAME_CYCLES - 160_000;
    localparam int REPLAY_HOLD    = 8;

    logic               clk;
    logic               reset;
    logic [7:0]         controller_report;
    logic [7:0]         vga_r;
    logic [7:0]         vga_g;
    logic [7:0]         vga_b;
    logic               vga_clk;
    logic               vga_hs;
    logic               vga_vs;
    logic               vga_blank_n;
    logic               vga_sync_n;
    logic [SCORE_W-1:0] score;
    logic               run_done;
    logic               check_error;
    logic [31:0]        lcg_state;
    int                 replay_delay;
    int                 cycles;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    dino_run #(
        .MOTION_TICKS (MOTION_TICKS)
    ) uut (
        .clk               (clk),
        .reset             (reset),
        .controller_report (controller_report),
        .vga_r             (vga_r),
        .vga_g             (vga_g),
        .vga_b             (vga_b),
        .vga_clk           (vga_clk),
        .vga_hs            (vga_hs),
        .vga_vs            (vga_vs),
        .vga_blank_n       (vga_blank_n),
        .vga_sync_n        (vga_sync_n),
        .score             (score)
    );

    dino_run_checks #(
        .MOTION_TICKS (MOTION_TICKS),
        .RUN_CYCLES   (RUN_CYCLES)
    ) checks (
        .clk               (clk),
        .reset             (reset),
        .controller_report (controller_report),
        .vga_r             (vga_r),
        .vga_g             (vga_g),
        .vga_b             (vga_b),
        .vga_clk           (vga_clk),
        .vga_hs            (vga_hs),
        .vga_vs            (vga_vs),
        .vga_blank_n       (vga_blank_n),
        .vga_sync_n        (vga_sync_n),
        .score             (score),
        .run_done          (run_done),
        .check_error       (check_error)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Simulation failed");
            $fatal(1, "timeout after %0d cycles without reaching the end of the run", cycles);
        end
    end

    always @(posedge check_error) begin
        $display("Simulation failed");
        $fatal(1, "stopped at the first failing check");
    end

    initial begin
        cycles            = 0;
        lcg_state         = 32'hde5e4155;
        controller_report = 8'h00;
        reset             = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // Replay press lands at a random point of the game-over window
        lcg_state    = lcg_next(lcg_state);
        replay_delay = int'(lcg_state[30:14]);
        repeat (REPLAY_BASE + replay_delay) @(negedge clk);
        controller_report[REPLAY_BIT] = 1'b1;
        repeat (REPLAY_HOLD) @(negedge clk);
        controller_report[REPLAY_BIT] = 1'b0;

        wait (run_done);
        repeat (2) @(negedge clk);
        if (check_error) begin
            $display("Simulation failed");
            $fatal(1, "a check failed during the run");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule
